//--- sim.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/pipe_reg.sv
verilog/fetch_unit.sv
verification/clk_gen.sv
verification/tb_fetch_unit.sv

//--- verification/clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset, 20 ns period
// rst is high from time 0 through the fifth rising edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int HALF_NS    = 10,  // Half period in ns
  parameter int RST_CYCLES = 5    // Rising edges seen with rst high
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;  // Rising edges at 10, 30, 50 ns ...
  end

  // Released on an edge, like every other DUT input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/tb_fetch_unit.sv
////////////////////////////////////////////////////////////
// Directed tests for the fetch front end
// Memory model answers addr ^ A5A5 in the same cycle
// Inputs change on the rising edge and if_id is read on the falling one
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"
`default_nettype none

module tb_fetch_unit;

  import fetch_pkg::*;

  localparam int BTB_N    = `FETCH_BTB_ENTRIES;
  localparam int WAIT_MAX = 16;  // Cycle budget of any wait loop

  // Training branch and an alias that shares only its index
  localparam logic [`FETCH_ADDR_W-1:0] BR_PC    = 16'h0345;
  localparam logic [`FETCH_ADDR_W-1:0] BR_TGT   = 16'h0100;
  localparam logic [`FETCH_ADDR_W-1:0] ALIAS_PC = BR_PC + `FETCH_ADDR_W'(BTB_N);

  logic                     clk;
  logic                     rst;
  logic [`FETCH_ADDR_W-1:0] imem_addr;
  logic [`FETCH_INST_W-1:0] imem_data;
  logic                     stall;
  redirect_t                redirect;
  branch_resolve_t          resolve;
  fetch_bundle_t            if_id;

  int     errors;
  int     checks;
  integer seed;

  // Reference state advanced once per rising edge
  logic [`FETCH_ADDR_W-1:0] exp_pc;                 // PC the DUT should present
  fetch_bundle_t            exp_if_id;
  logic                     model_valid  [BTB_N];
  logic [1:0]               model_ctr    [BTB_N];
  logic [`FETCH_ADDR_W-1:0] model_branch [BTB_N];  // Full branch address stands in for the tag
  logic [`FETCH_ADDR_W-1:0] model_target [BTB_N];

  clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  fetch_unit u_dut (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .stall     (stall),
    .redirect  (redirect),
    .resolve   (resolve),
    .if_id     (if_id)
  );

  assign imem_data = imem_addr ^ 16'hA5A5;  // Combinational instruction memory

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic redirect_t redir_to(input logic [`FETCH_ADDR_W-1:0] addr);
    redirect_t r;
    r.valid  = 1'b1;
    r.target = addr;
    return r;
  endfunction

  function automatic branch_resolve_t resolved(input logic [`FETCH_ADDR_W-1:0] pc,
                                               input logic taken,
                                               input logic [`FETCH_ADDR_W-1:0] target);
    branch_resolve_t b;
    b.valid  = 1'b1;
    b.pc     = pc;
    b.taken  = taken;
    b.target = target;
    return b;
  endfunction

  // Taken only on a valid matching entry with counter bit 1 set
  function automatic fetch_bundle_t expected_bundle(input logic [`FETCH_ADDR_W-1:0] pc);
    fetch_bundle_t b;
    int            i;
    logic          hit;
    i   = int'(pc) % BTB_N;
    hit = model_valid[i] && (model_branch[i] == pc);
    b.valid            = 1'b1;
    b.pc_curr          = pc;
    b.inst             = pc ^ 16'hA5A5;
    b.prediction       = hit ? model_ctr[i] : 2'b01;  // Miss reads weakly not taken
    b.predicted_target = hit ? model_target[i] : '0;
    b.pc_next          = (hit && model_ctr[i][1]) ? model_target[i] : pc + 16'd1;
    return b;
  endfunction

  function automatic void train_model(input branch_resolve_t res);
    int i;
    i = int'(res.pc) % BTB_N;
    if (!(model_valid[i] && model_branch[i] == res.pc)) begin
      if (res.taken) begin  // Allocate on taken only and overwrite any alias
        model_valid[i]  = 1'b1;
        model_branch[i] = res.pc;
        model_target[i] = res.target;
        model_ctr[i]    = 2'b10;
      end
    end else if (res.taken) begin
      model_target[i] = res.target;
      if (model_ctr[i] != 2'b11)
        model_ctr[i] = model_ctr[i] + 2'd1;
    end else if (model_ctr[i] != 2'b00) begin
      model_ctr[i] = model_ctr[i] - 2'd1;
    end
  endfunction

  // Lookup uses the table before this edge's update
  always @(posedge clk) begin
    if (rst) begin
      exp_pc    = '0;
      exp_if_id = '0;
      for (int i = 0; i < BTB_N; i++) begin
        model_valid[i]  = 1'b0;
        model_ctr[i]    = 2'b01;
        model_branch[i] = '0;
        model_target[i] = '0;
      end
    end else begin
      if (redirect.valid) begin  // Beats stall
        exp_if_id = '0;
        exp_pc    = redirect.target;
      end else if (!stall) begin
        exp_if_id = expected_bundle(exp_pc);
        exp_pc    = exp_if_id.pc_next;
      end
      if (resolve.valid)
        train_model(resolve);
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks and cycle helpers
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [95:0] exp,
                             input logic [95:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond)
      else begin
        errors++;
        $display("ERROR at %0t: %s", $time, what);
      end
  endtask

  // Sets inputs for the next edge and then reads the edge just taken
  task automatic run_cycle(input logic s, input redirect_t r, input branch_resolve_t res);
    @(posedge clk);
    stall    <= s;
    redirect <= r;
    resolve  <= res;
    @(negedge clk);
    check_value("imem_addr", exp_pc, imem_addr);
    check_value("if_id", exp_if_id, if_id);
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, '0, '0);
  endtask

  task automatic wait_for_fetch(input logic [`FETCH_ADDR_W-1:0] addr);
    int n;
    n = 0;
    while (!(if_id.valid && if_id.pc_curr == addr) && n < WAIT_MAX) begin
      idle_cycle();
      n++;
    end
    check_true(if_id.valid && if_id.pc_curr == addr,
               $sformatf("timed out waiting for a fetch at %0h", addr));
  endtask

  // Redirect to addr and expect a bubble before addr reaches if_id
  task automatic fetch_at(input logic [`FETCH_ADDR_W-1:0] addr);
    run_cycle(1'b0, redir_to(addr), '0);
    idle_cycle();
    check_value("if_id", '0, if_id);
    wait_for_fetch(addr);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic reset_and_sequential();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      check_value("if_id.valid", 1'b0, if_id.valid);
      n++;
    end while (rst !== 1'b0 && n < 4 * WAIT_MAX);
    check_true(rst === 1'b0, "reset was never released");
    check_value("if_id", '0, if_id);        // Still a bubble before the first edge
    check_value("imem_addr", '0, imem_addr);
    for (int k = 0; k < 8; k++) begin
      idle_cycle();
      check_value("if_id.valid", 1'b1, if_id.valid);
      check_value("if_id.pc_curr", k, if_id.pc_curr);
      check_value("if_id.pc_next", k + 1, if_id.pc_next);
      check_value("if_id.inst", k ^ 16'hA5A5, if_id.inst);
      check_value("if_id.prediction", 2'b01, if_id.prediction);
    end
  endtask

  task automatic random_stall();
    fetch_bundle_t prev;
    logic          s;
    logic          held;     // Stall level the coming edge sees
    int            stalled;
    stalled = 0;
    prev    = if_id;
    for (int k = 0; k < 40; k++) begin
      s    = ($random(seed) & 32'd1) != 0;
      held = stall;
      run_cycle(s, '0, '0);
      if (held) begin
        stalled++;
        check_value("if_id (stalled edge)", prev, if_id);
      end else begin
        check_value("if_id.valid", 1'b1, if_id.valid);
        check_value("if_id.pc_curr", prev.pc_curr + 16'd1, if_id.pc_curr);  // No gap or repeat
      end
      prev = if_id;
    end
    check_true(stalled > 0, "random stall pattern never stalled");
    idle_cycle();
  endtask

  task automatic redirect_paths();
    // Free running
    run_cycle(1'b0, redir_to(16'h0120), '0);
    idle_cycle();
    check_value("if_id", '0, if_id);
    idle_cycle();
    check_value("if_id.valid", 1'b1, if_id.valid);
    check_value("if_id.pc_curr", 16'h0120, if_id.pc_curr);
    // Redirect lands on a stalled edge
    run_cycle(1'b1, '0, '0);
    run_cycle(1'b1, redir_to(16'h0300), '0);
    run_cycle(1'b0, '0, '0);
    check_value("if_id", '0, if_id);
    idle_cycle();
    check_value("if_id.valid", 1'b1, if_id.valid);
    check_value("if_id.pc_curr", 16'h0300, if_id.pc_curr);
  endtask

  task automatic train_to_taken();
    run_cycle(1'b0, '0, resolved(BR_PC, 1'b1, BR_TGT));  // Allocates at 10
    run_cycle(1'b0, '0, resolved(BR_PC, 1'b1, BR_TGT));  // Then 11
    idle_cycle();
    fetch_at(BR_PC - 16'd2);                             // Walk into the branch
    wait_for_fetch(BR_PC);
    check_value("if_id.prediction", 2'b11, if_id.prediction);
    check_value("if_id.predicted_target", BR_TGT, if_id.predicted_target);
    check_value("if_id.pc_next", BR_TGT, if_id.pc_next);
    idle_cycle();
    check_value("if_id.pc_curr", BR_TGT, if_id.pc_curr);
  endtask

  task automatic train_back_and_alias();
    logic [1:0] exp_ctr;
    int         dut_flip;
    int         model_flip;
    int         xi;
    exp_ctr    = 2'b11;
    dut_flip   = 0;
    model_flip = 0;
    xi         = int'(BR_PC) % BTB_N;
    for (int step = 1; step <= 4; step++) begin
      run_cycle(1'b0, '0, resolved(BR_PC, 1'b0, '0));
      exp_ctr = (exp_ctr == 2'b00) ? 2'b00 : exp_ctr - 2'd1;  // Saturates at 00
      fetch_at(BR_PC);
      check_value("if_id.prediction", exp_ctr, if_id.prediction);
      check_value("if_id.pc_next", exp_ctr[1] ? BR_TGT : BR_PC + 16'd1, if_id.pc_next);
      if (dut_flip == 0 && if_id.pc_next != BR_TGT)
        dut_flip = step;
      if (model_flip == 0 && !(model_valid[xi] && model_ctr[xi][1]))
        model_flip = step;
    end
    check_value("prediction flip step", model_flip, dut_flip);
    // Alias at the same index with another tag and no entry
    fetch_at(ALIAS_PC);
    check_value("if_id.prediction", 2'b01, if_id.prediction);
    check_value("if_id.pc_next", ALIAS_PC + 16'd1, if_id.pc_next);
    check_value("if_id.predicted_target", '0, if_id.predicted_target);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed     = 72946;
    errors   = 0;
    checks   = 0;
    stall    = 1'b0;
    redirect = '0;
    resolve  = '0;
    reset_and_sequential();
    random_stall();
    redirect_paths();
    train_to_taken();
    train_back_and_alias();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/branch_predictor.sv
////////////////////////////////////////////////////////////
// Direct mapped BTB with a 2-bit saturating counter each
// Lookup is combinational, updates land at the clock edge
// A miss reads as counter 01 and target 0, never taken
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"
`default_nettype none

module branch_predictor (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`FETCH_ADDR_W-1:0]    lookup_pc,  // Current fetch PC
  output fetch_pkg::pred_t            pred,       // Result for lookup_pc
  input  fetch_pkg::branch_resolve_t  resolve     // Training from execute
);

  localparam int ENTRIES = `FETCH_BTB_ENTRIES;
  localparam int IDX_W   = $clog2(ENTRIES);
  localparam int TAG_W   = `FETCH_ADDR_W - IDX_W;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  logic                     btb_valid  [ENTRIES];
  logic [1:0]               btb_ctr    [ENTRIES];  // 00 strong NT .. 11 strong T
  logic [TAG_W-1:0]         btb_tag    [ENTRIES];
  logic [`FETCH_ADDR_W-1:0] btb_target [ENTRIES];

  // Lookup side
  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;
  logic             lk_hit;

  // Update side
  logic [IDX_W-1:0] rs_idx;
  logic [TAG_W-1:0] rs_tag;
  logic             rs_hit;
  logic [1:0]       rs_ctr;
  logic [1:0]       ctr_inc;
  logic [1:0]       ctr_dec;
  logic             alloc;     // Taken branch with no entry yet
  logic             train;     // Resolve for a branch already held

  ////////////////////////////////////////////////////////////
  // Combinational lookup
  ////////////////////////////////////////////////////////////
  assign lk_idx = lookup_pc[IDX_W-1:0];
  assign lk_tag = lookup_pc[`FETCH_ADDR_W-1:IDX_W];
  assign lk_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);

  always_comb begin
    pred.taken   = lk_hit && btb_ctr[lk_idx][1];  // Upper counter bit is the direction
    pred.counter = lk_hit ? btb_ctr[lk_idx] : 2'b01;
    pred.target  = lk_hit ? btb_target[lk_idx] : '0;
  end

  ////////////////////////////////////////////////////////////
  // Update decode
  ////////////////////////////////////////////////////////////
  assign rs_idx = resolve.pc[IDX_W-1:0];
  assign rs_tag = resolve.pc[`FETCH_ADDR_W-1:IDX_W];
  assign rs_hit = btb_valid[rs_idx] && (btb_tag[rs_idx] == rs_tag);
  assign rs_ctr = btb_ctr[rs_idx];

  // Saturate at both ends
  assign ctr_inc = (rs_ctr == 2'b11) ? 2'b11 : rs_ctr + 2'd1;
  assign ctr_dec = (rs_ctr == 2'b00) ? 2'b00 : rs_ctr - 2'd1;

  assign alloc = resolve.valid && resolve.taken && !rs_hit;
  assign train = resolve.valid && rs_hit;

  // Valid bits and counters
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        btb_valid[i] <= 1'b0;
        btb_ctr[i]   <= 2'b01;   // Weakly not taken
      end
    end else if (alloc) begin
      btb_valid[rs_idx] <= 1'b1;  // Replaces any alias at this index
      btb_ctr[rs_idx]   <= 2'b10; // Start weakly taken
    end else if (train) begin
      btb_ctr[rs_idx] <= resolve.taken ? ctr_inc : ctr_dec;
    end
  end

  // Tag and target, only written on a taken resolve
  always_ff @(posedge clk) begin
    if (resolve.valid && resolve.taken) begin
      btb_tag[rs_idx]    <= rs_tag;          // Unchanged on a hit
      btb_target[rs_idx] <= resolve.target;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  // Outside an allocation every counter moves by at most one step per edge
  for (genvar gi = 0; gi < ENTRIES; gi++) begin : g_ctr_chk
    a_ctr_step: assert property (
      @(posedge clk) disable iff (rst)
      !(alloc && (rs_idx == IDX_W'(gi))) |=>
        (2'(btb_ctr[gi] - $past(btb_ctr[gi])) inside {2'd0, 2'd1, 2'd3})
    ) else $error("BTB counter %0d jumped more than one step", gi);
  end

endmodule

`default_nettype wire

//--- verilog/fetch_params.svh
////////////////////////////////////////////////////////////
// Fetch front end sizing, word addressed throughout
// BTB depth must be a power of two, index is the low PC bits
// and the tag is whatever address bits are left above it
////////////////////////////////////////////////////////////
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Word address width, one instruction per address
`define FETCH_ADDR_W 16

// Instruction word width
`define FETCH_INST_W 16

// Branch target buffer entries
// 16 entries gives 4 index bits and 12 tag bits
`define FETCH_BTB_ENTRIES 16

`endif

//--- verilog/fetch_pkg.sv
////////////////////////////////////////////////////////////
// Shared fetch types, widths come from the params header
// An all zero fetch bundle is a bubble (valid low)
////////////////////////////////////////////////////////////
`include "fetch_params.svh"
`default_nettype none

package fetch_pkg;

  // IF/ID payload, 67 bits
  typedef struct packed {
    logic                     valid;            // Real instruction, not a bubble
    logic [`FETCH_ADDR_W-1:0] pc_curr;          // Address of this instruction
    logic [`FETCH_ADDR_W-1:0] pc_next;          // Address fetched after it
    logic [`FETCH_INST_W-1:0] inst;             // Instruction word
    logic [1:0]               prediction;       // 2-bit counter seen at lookup
    logic [`FETCH_ADDR_W-1:0] predicted_target; // Target held in the BTB
  } fetch_bundle_t;

  // Redirect from execute, 17 bits
  typedef struct packed {
    logic                     valid;
    logic [`FETCH_ADDR_W-1:0] target;  // New fetch address
  } redirect_t;

  // Resolved branch from execute, 34 bits
  typedef struct packed {
    logic                     valid;
    logic [`FETCH_ADDR_W-1:0] pc;      // Address of the branch
    logic                     taken;   // Actual direction
    logic [`FETCH_ADDR_W-1:0] target;  // Actual target when taken
  } branch_resolve_t;

  // BTB lookup result, 19 bits
  typedef struct packed {
    logic                     taken;    // Predict taken
    logic [1:0]               counter;  // 01 on a miss
    logic [`FETCH_ADDR_W-1:0] target;   // Zero on a miss
  } pred_t;

endpackage

`default_nettype wire

//--- verilog/fetch_unit.sv
////////////////////////////////////////////////////////////
// Fetch front end, PC to IF/ID
// imem_data must answer imem_addr in the same cycle
// No handshake: stall holds, redirect flushes and steers
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"
`default_nettype none

module fetch_unit (
  input  logic                        clk,
  input  logic                        rst,

  // Instruction memory, word addressed
  output logic [`FETCH_ADDR_W-1:0]    imem_addr,
  input  logic [`FETCH_INST_W-1:0]    imem_data,

  // Decode back-pressure
  input  logic                        stall,

  // Execute feedback
  input  fetch_pkg::redirect_t        redirect,
  input  fetch_pkg::branch_resolve_t  resolve,

  // To decode
  output fetch_pkg::fetch_bundle_t    if_id
);

  import fetch_pkg::*;

  pred_t         pred;    // BTB lookup for the current PC
  fetch_bundle_t bundle;  // Fetch result before IF/ID

  ////////////////////////////////////////////////////////////
  // PC generation, PC goes straight out to memory
  ////////////////////////////////////////////////////////////
  pc_gen u_pc_gen (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .redirect (redirect),
    .pred     (pred),
    .inst     (imem_data),
    .pc       (imem_addr),
    .bundle   (bundle)
  );

  ////////////////////////////////////////////////////////////
  // Branch prediction, looked up on the same PC
  ////////////////////////////////////////////////////////////
  branch_predictor u_branch_predictor (
    .clk       (clk),
    .rst       (rst),
    .lookup_pc (imem_addr),
    .pred      (pred),
    .resolve   (resolve)   // Trains even while stalled
  );

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////
  pipe_reg #(
    .payload_t (fetch_bundle_t)
  ) u_if_id_reg (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .flush (redirect.valid),  // Wrong path fetch becomes a bubble
    .d     (bundle),
    .q     (if_id)
  );

endmodule

`default_nettype wire

//--- verilog/pc_gen.sv
////////////////////////////////////////////////////////////
// Program counter and fetch bundle assembly
// Redirect beats stall, stall holds the PC
// inst must be the memory word at pc in the same cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"
`default_nettype none

module pc_gen (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,     // Back-pressure from decode
  input  fetch_pkg::redirect_t     redirect,  // From execute
  input  fetch_pkg::pred_t         pred,      // BTB lookup for pc, same cycle
  input  logic [`FETCH_INST_W-1:0] inst,      // Instruction memory data
  output logic [`FETCH_ADDR_W-1:0] pc,        // Current fetch address
  output fetch_pkg::fetch_bundle_t bundle     // Into the IF/ID register
);

  logic [`FETCH_ADDR_W-1:0] pc_next;  // Predicted or sequential successor

  // Follow the BTB when it says taken, else fall through
  assign pc_next = pred.taken ? pred.target : pc + `FETCH_ADDR_W'(1);

  ////////////////////////////////////////////////////////////
  // PC register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      pc <= '0;                  // Fetch starts at word 0
    else if (redirect.valid)
      pc <= redirect.target;     // Mispredict or jump, stall ignored
    else if (!stall)
      pc <= pc_next;
  end

  ////////////////////////////////////////////////////////////
  // Bundle for this fetch
  ////////////////////////////////////////////////////////////
  always_comb begin
    bundle.valid            = 1'b1;          // Bubbles only come from a flush
    bundle.pc_curr          = pc;
    bundle.pc_next          = pc_next;
    bundle.inst             = inst;
    bundle.prediction       = pred.counter;
    bundle.predicted_target = pred.target;   // Decode compares against this later
  end

  // Execute must present a clean target whenever it redirects
  a_redirect_known: assert property (
    @(posedge clk) disable iff (rst)
    redirect.valid |-> !$isunknown(redirect.target)
  ) else $error("redirect.target unknown while redirect.valid");

endmodule

`default_nettype wire

//--- verilog/pipe_reg.sv
////////////////////////////////////////////////////////////
// Stage register for any packed payload
// Flush beats stall, reset and flush both give all zeros
// A zero payload must mean a bubble for the stage behind
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic [31:0]  // Stage payload, packed
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,  // Hold q, downstream not ready
  input  logic     flush,  // Kill the held entry
  input  payload_t d,
  output payload_t q
);

  logic clr;  // Zero the register
  logic wen;  // Take d

  assign clr = rst | flush;
  assign wen = ~stall;

  ////////////////////////////////////////////////////////////
  // Register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clr)
      q <= '0;      // Whole payload, valid included
    else if (wen)
      q <= d;
  end

  // A flush always leaves a bubble, stalled or not
  a_flush_clears: assert property (
    @(posedge clk) disable iff (rst)
    flush |=> (q == '0)
  ) else $error("pipe_reg not cleared after flush");

endmodule

`default_nettype wire
